//--- cdbus_pkg.sv
// ########################################################
// cdbus shared types: configuration, status pulses, apb
// register map and buffer widths
// ########################################################
package cdbus_pkg;

    localparam int APB_AW = 8;

    typedef logic [7:0] ram_addr_t;
    typedef logic [7:0] ram_data_t;

    typedef struct packed {
        logic [15:0] div_ls;      // first byte of a frame
        logic [15:0] div_hs;      // remaining bytes
        logic        user_crc;    // host supplies the crc bytes
        logic        arbitrate;
        logic [1:0]  tx_en_delay; // head length in low-speed bits, minus one
    } cdbus_cfg_t;

    typedef struct packed {
        logic read_done;
        logic cd;
        logic cd_err;
    } tx_status_t;

    typedef struct packed {
        logic       frame_done;
        logic       crc_err;
        logic [7:0] frame_len;
    } rx_status_t;

    // apb register offsets
    localparam logic [APB_AW-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_AW-1:0] REG_DIV      = 8'h04;
    localparam logic [APB_AW-1:0] REG_TX_DATA  = 8'h08;
    localparam logic [APB_AW-1:0] REG_TX_START = 8'h0C;
    localparam logic [APB_AW-1:0] REG_RX_DATA  = 8'h10;
    localparam logic [APB_AW-1:0] REG_STATUS   = 8'h14;

endpackage

//--- serial_crc.sv
`timescale 1ns/1ns
// ########################################################
// bit-serial crc-16 (modbus), one bit per data_clk
// ########################################################
module serial_crc (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        clean,    // hold at initial value
    input  logic        data_clk,
    input  logic        data_in,
    output logic [15:0] crc_out
);

    logic [15:0] crc;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            crc <= 16'hFFFF;
        end else if (clean) begin
            crc <= 16'hFFFF;
        end else if (data_clk) begin
            // reflected form, lsb first
            crc <= {1'b0, crc[15:1]} ^ ((crc[0] ^ data_in) ? 16'hA001 : 16'h0000);
        end
    end

    assign crc_out = crc;

endmodule

//--- pkt_ram.sv
`timescale 1ns/1ns
// ########################################################
// byte-wide packet buffer, synchronous write, async read
// ########################################################
module pkt_ram
    import cdbus_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic      clk,
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  ram_data_t wr_data,
    input  ram_addr_t rd_addr,
    output ram_data_t rd_data
);

    ram_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // valid in the same cycle as the address
    assign rd_data = mem[rd_addr];

endmodule

//--- tx_bytes_ser.sv
`timescale 1ns/1ns
// ########################################################
// frame serializer: bit-rate divider, tx_en head, bus
// arbitration with retry, crc insertion
// ########################################################
module tx_bytes_ser
    import cdbus_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  cdbus_cfg_t cfg,
    input  logic       unread,
    input  ram_data_t  data,
    output ram_addr_t  addr,
    input  logic       tx_permit,
    input  logic       rx,
    output logic       tx,
    output logic       tx_en,
    output tx_status_t tx_st
);

    typedef enum logic [3:0] {
        WAIT       = 4'b0001,
        DELAY_HEAD = 4'b0010,
        DELAY_END  = 4'b0100,
        DATA       = 4'b1000
    } state_t;

    state_t      state;
    logic        hs_flag;
    logic        bit_inc;
    logic        bit_mid;
    logic [15:0] div_cnt;
    logic [15:0] div_cur;
    logic [1:0]  delay_cnt;
    logic [3:0]  bit_cnt;      // 0..9, start and stop included
    logic        bit_finished;
    logic        tx_en_dyn;    // open-drain style drive during arbitration
    logic        crc_clk;
    logic        byte_inc;
    ram_data_t   tx_byte;
    logic [9:0]  tx_data;
    logic [8:0]  byte_cnt;
    ram_data_t   data_len;
    logic        is_crc_byte;
    logic        is_last_byte;
    logic [15:0] crc_data;
    logic [1:0]  retry_cnt;
    logic        cd;
    logic        cd_err;
    logic        read_done;

    assign div_cur = hs_flag ? cfg.div_hs : cfg.div_ls;
    assign tx_data = {1'b1, tx_byte, 1'b0};
    assign addr    = byte_cnt[7:0];
    assign tx_st   = '{read_done, cd, cd_err};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= WAIT;
        end else begin
            case (state)
                WAIT: begin
                    if (tx_permit && unread)
                        state <= cfg.arbitrate ? DATA : DELAY_HEAD;
                end
                DELAY_HEAD: begin
                    if (bit_inc && delay_cnt == cfg.tx_en_delay)
                        state <= DELAY_END;
                end
                DELAY_END: state <= DATA; // lets the divider restart
                DATA: begin
                    if (cd || (is_last_byte && byte_inc))
                        state <= WAIT;
                end
                default: state <= WAIT;
            endcase
        end
    end

    // bit timing, bit_mid at 3/4 of a bit
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= 16'd1;
            bit_inc <= 1'b0;
            bit_mid <= 1'b0;
        end else begin
            bit_inc <= 1'b0;
            bit_mid <= 1'b0;
            if (state == WAIT || state == DELAY_END) begin
                div_cnt <= 16'd1;
            end else begin
                div_cnt <= div_cnt + 16'd1;
                if (div_cnt == div_cur - {2'b00, div_cur[15:2]})
                    bit_mid <= 1'b1;
                if (div_cnt >= div_cur) begin
                    div_cnt <= '0;
                    bit_inc <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            delay_cnt <= '0;
        else if (state == WAIT)
            delay_cnt <= '0;
        else if (bit_inc)
            delay_cnt <= delay_cnt + 2'd1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hs_flag      <= 1'b0;
            crc_clk      <= 1'b0;
            cd           <= 1'b0;
            byte_inc     <= 1'b0;
            bit_cnt      <= '0;
            bit_finished <= 1'b0;
            tx_en_dyn    <= 1'b1;
            tx           <= 1'b1;
            tx_en        <= 1'b0;
        end else begin
            crc_clk  <= 1'b0;
            cd       <= 1'b0;
            byte_inc <= 1'b0;
            if (state != DATA) begin
                hs_flag      <= 1'b0;
                bit_cnt      <= '0;
                bit_finished <= 1'b0;
                tx_en_dyn    <= 1'b1;
                tx           <= 1'b1;
                tx_en        <= (state != WAIT); // delay head
            end else if (!bit_finished) begin
                tx    <= tx_data[bit_cnt];
                tx_en <= !(cfg.arbitrate && tx_en_dyn && tx_data[bit_cnt]);
                // we send 1 but someone else pulls the bus low
                if (cfg.arbitrate && tx_en_dyn && bit_mid && tx && !rx)
                    cd <= 1'b1;
                if (bit_inc) begin
                    crc_clk <= bit_cnt != 4'd0 && bit_cnt != 4'd9 && !is_crc_byte;
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd9) begin
                        hs_flag   <= 1'b1;
                        bit_cnt   <= '0;
                        byte_inc  <= 1'b1;
                        tx_en_dyn <= 1'b0; // arbitration won after first byte
                        if (is_last_byte)
                            bit_finished <= 1'b1;
                    end
                end
            end
        end
    end

    // byte fetch, the next byte is loaded long before its first data bit
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt     <= '0;
            data_len     <= '0;
            is_crc_byte  <= 1'b0;
            is_last_byte <= 1'b0;
            tx_byte      <= '0;
        end else if (state != DATA) begin
            byte_cnt     <= '0;
            data_len     <= '0;
            is_crc_byte  <= 1'b0;
            is_last_byte <= 1'b0;
        end else begin
            tx_byte <= data;
            if (byte_cnt == 9'd2) begin
                data_len <= data;
            end else if (byte_cnt == {1'b0, data_len} + 9'd3) begin
                if (!cfg.user_crc)
                    tx_byte <= crc_data[7:0];
                is_crc_byte <= 1'b1;
            end else if (byte_cnt == {1'b0, data_len} + 9'd4) begin
                if (!cfg.user_crc)
                    tx_byte <= crc_data[15:8];
                is_last_byte <= 1'b1;
            end
            if (byte_inc)
                byte_cnt <= byte_cnt + 9'd1;
        end
    end

    // four collisions in a row drop the frame
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            retry_cnt <= '0;
            read_done <= 1'b0;
            cd_err    <= 1'b0;
        end else begin
            read_done <= 1'b0;
            cd_err    <= 1'b0;
            if (cd) begin
                retry_cnt <= retry_cnt + 2'd1; // wraps to 0 on the drop
                if (retry_cnt == 2'd3) begin
                    read_done <= 1'b1;
                    cd_err    <= 1'b1;
                end
            end else if (is_last_byte && byte_inc) begin
                read_done <= 1'b1;
                retry_cnt <= '0;
            end
        end
    end

    serial_crc i_tx_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (state != DATA),
        .data_clk (crc_clk),
        .data_in  (tx),
        .crc_out  (crc_data)
    );

endmodule

//--- rx_bytes_des.sv
`timescale 1ns/1ns
// ########################################################
// frame deserializer with crc check and bus idle detect
// ########################################################
module rx_bytes_des
    import cdbus_pkg::*;
#(
    parameter int IDLE_BITS = 10
) (
    input  logic       clk,
    input  logic       reset_n,
    input  cdbus_cfg_t cfg,
    input  logic       rx,
    output logic       wr_en,
    output ram_addr_t  wr_addr,
    output ram_data_t  wr_data,
    output logic       tx_permit,
    output rx_status_t rx_st
);

    logic        rx_s1;
    logic        rx_s2;
    logic        rx_d;
    logic        rx_fall;
    logic        in_char;
    logic        hs_flag;
    logic        sample;
    logic [15:0] div_cnt;
    logic [15:0] div_cur;
    logic [3:0]  bit_cnt;
    ram_data_t   shreg;
    logic [8:0]  byte_cnt;
    ram_data_t   data_len;
    logic        crc_clk;
    logic [15:0] crc_data;
    logic [15:0] idle_div;
    logic [7:0]  idle_cnt;
    logic        frame_done;
    logic        crc_err;
    logic [7:0]  frame_len;

    assign rx_fall = rx_d && !rx_s2;
    assign div_cur = hs_flag ? cfg.div_hs : cfg.div_ls;
    // start bit sampled at half a bit, the rest one bit apart
    assign sample  = in_char && (bit_cnt == 4'd0 ? div_cnt == {1'b0, div_cur[15:1]}
                                                  : div_cnt >= div_cur);
    assign rx_st   = '{frame_done, crc_err, frame_len};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            in_char <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            crc_clk <= 1'b0;
        end else begin
            crc_clk <= 1'b0;
            if (!in_char) begin
                div_cnt <= '0;
                bit_cnt <= '0;
                if (rx_fall)
                    in_char <= 1'b1;
            end else if (sample) begin
                div_cnt <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0 && rx_s2)
                    in_char <= 1'b0; // glitch, no real start bit
                if (bit_cnt != 4'd0 && bit_cnt != 4'd9)
                    crc_clk <= 1'b1;
                if (bit_cnt == 4'd9)
                    in_char <= 1'b0;
            end else begin
                div_cnt <= div_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shreg <= {rx_s2, shreg[7:1]}; // lsb first
        if (sample && bit_cnt == 4'd9) begin
            wr_addr <= byte_cnt[7:0];
            wr_data <= shreg;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt   <= '0;
            data_len   <= '0;
            hs_flag    <= 1'b0;
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
            crc_err    <= 1'b0;
            frame_len  <= '0;
        end else begin
            wr_en      <= 1'b0;
            frame_done <= 1'b0;
            crc_err    <= 1'b0;
            if (tx_permit) begin
                byte_cnt <= '0; // bus went idle, drop any partial frame
                hs_flag  <= 1'b0;
            end else if (sample && bit_cnt == 4'd9) begin
                wr_en    <= 1'b1;
                hs_flag  <= 1'b1;
                byte_cnt <= byte_cnt + 9'd1;
                if (byte_cnt == 9'd2)
                    data_len <= shreg;
                if (byte_cnt > 9'd2 && byte_cnt == {1'b0, data_len} + 9'd4) begin
                    frame_done <= 1'b1;
                    crc_err    <= crc_data != 16'h0000; // residue over data and crc
                    frame_len  <= byte_cnt[7:0];
                    byte_cnt   <= '0;
                    hs_flag    <= 1'b0;
                end
            end
        end
    end

    // idle time counted in low-speed bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            idle_div  <= '0;
            idle_cnt  <= '0;
            tx_permit <= 1'b0;
        end else if (in_char || !rx_s2) begin
            idle_div  <= '0;
            idle_cnt  <= '0;
            tx_permit <= 1'b0;
        end else if (!tx_permit) begin
            idle_div <= idle_div + 16'd1;
            if (idle_div >= cfg.div_ls) begin
                idle_div <= '0;
                idle_cnt <= idle_cnt + 8'd1;
                if (idle_cnt == 8'(IDLE_BITS - 1))
                    tx_permit <= 1'b1;
            end
        end
    end

    serial_crc i_rx_crc (
        .clk      (clk),
        .reset_n  (reset_n),
        .clean    (byte_cnt == 9'd0 && !in_char),
        .data_clk (crc_clk),
        .data_in  (shreg[7]),
        .crc_out  (crc_data)
    );

endmodule

//--- cdbus_regs.sv
`timescale 1ns/1ns
// ########################################################
// apb register block: config, buffer access, sticky status
// ########################################################
module cdbus_regs
    import cdbus_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output cdbus_cfg_t        cfg,
    output logic              tx_wr_en,
    output ram_addr_t         tx_wr_addr,
    output ram_data_t         tx_wr_data,
    output logic              unread,
    input  tx_status_t        tx_st,
    output ram_addr_t         rx_rd_addr,
    input  ram_data_t         rx_rd_data,
    input  rx_status_t        rx_st
);

    logic        wr_acc;
    logic        rd_acc;
    ram_addr_t   tx_wptr;
    ram_addr_t   rx_rptr;
    logic        tx_done;
    logic        cd_err;
    logic        rx_done;
    logic        rx_crc_err;
    logic [7:0]  frame_len;
    logic [31:0] status;

    assign wr_acc     = psel && penable && pwrite;
    assign rd_acc     = psel && penable && !pwrite;
    assign pready     = 1'b1; // no wait states
    assign tx_wr_en   = wr_acc && paddr == REG_TX_DATA;
    assign tx_wr_addr = tx_wptr;
    assign tx_wr_data = pwdata[7:0];
    assign rx_rd_addr = rx_rptr;
    assign status     = {16'd0, frame_len, 3'd0, unread, rx_crc_err, rx_done, cd_err, tx_done};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg <= '{div_ls: 16'd99, div_hs: 16'd9, default: '0};
        end else if (wr_acc) begin
            case (paddr)
                REG_CTRL: begin
                    cfg.user_crc    <= pwdata[0];
                    cfg.arbitrate   <= pwdata[1];
                    cfg.tx_en_delay <= pwdata[3:2];
                end
                REG_DIV: begin
                    cfg.div_ls <= pwdata[15:0];
                    cfg.div_hs <= pwdata[31:16];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_wptr <= '0;
            rx_rptr <= '0;
            unread  <= 1'b0;
        end else begin
            if (tx_wr_en)
                tx_wptr <= tx_wptr + 8'd1;
            if (tx_st.read_done)
                unread <= 1'b0;
            else if (wr_acc && paddr == REG_TX_START && !unread) begin
                unread  <= 1'b1; // busy start is ignored
                tx_wptr <= '0;
            end
            if (rx_st.frame_done)
                rx_rptr <= '0;
            else if (rd_acc && paddr == REG_RX_DATA)
                rx_rptr <= rx_rptr + 8'd1;
        end
    end

    // write 1 to clear, a new event wins over the clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tx_done    <= 1'b0;
            cd_err     <= 1'b0;
            rx_done    <= 1'b0;
            rx_crc_err <= 1'b0;
            frame_len  <= '0;
        end else begin
            if (wr_acc && paddr == REG_STATUS) begin
                if (pwdata[0])
                    tx_done <= 1'b0;
                if (pwdata[1])
                    cd_err <= 1'b0;
                if (pwdata[2])
                    rx_done <= 1'b0;
                if (pwdata[3])
                    rx_crc_err <= 1'b0;
            end
            if (tx_st.read_done && !tx_st.cd_err)
                tx_done <= 1'b1;
            if (tx_st.cd_err)
                cd_err <= 1'b1;
            if (rx_st.frame_done) begin
                rx_done   <= 1'b1;
                frame_len <= rx_st.frame_len;
            end
            if (rx_st.crc_err)
                rx_crc_err <= 1'b1;
        end
    end

    always_comb begin
        case (paddr)
            REG_CTRL:    prdata = {28'd0, cfg.tx_en_delay, cfg.arbitrate, cfg.user_crc};
            REG_DIV:     prdata = {cfg.div_hs, cfg.div_ls};
            REG_TX_DATA: prdata = {24'd0, tx_wptr};
            REG_RX_DATA: prdata = {24'd0, rx_rd_data};
            REG_STATUS:  prdata = status;
            default:     prdata = '0;
        endcase
    end

endmodule

//--- cdbus_ctrl.sv
`timescale 1ns/1ns
// ########################################################
// cdbus node top: registers, packet buffers, tx and rx paths
// ########################################################
module cdbus_ctrl
    import cdbus_pkg::*;
#(
    parameter int DEPTH     = 256,
    parameter int IDLE_BITS = 10
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_AW-1:0] paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              tx,
    output logic              tx_en,
    input  logic              rx
);

    cdbus_cfg_t cfg;
    tx_status_t tx_st;
    rx_status_t rx_st;
    logic       unread;
    logic       tx_permit;
    logic       tx_wr_en;
    ram_addr_t  tx_wr_addr;
    ram_data_t  tx_wr_data;
    ram_addr_t  tx_rd_addr;
    ram_data_t  tx_rd_data;
    logic       rx_wr_en;
    ram_addr_t  rx_wr_addr;
    ram_data_t  rx_wr_data;
    ram_addr_t  rx_rd_addr;
    ram_data_t  rx_rd_data;

    cdbus_regs i_cdbus_regs (
        .clk        (clk),
        .reset_n    (reset_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .cfg        (cfg),
        .tx_wr_en   (tx_wr_en),
        .tx_wr_addr (tx_wr_addr),
        .tx_wr_data (tx_wr_data),
        .unread     (unread),
        .tx_st      (tx_st),
        .rx_rd_addr (rx_rd_addr),
        .rx_rd_data (rx_rd_data),
        .rx_st      (rx_st)
    );

    pkt_ram #(.DEPTH(DEPTH)) i_tx_ram (
        .clk     (clk),
        .wr_en   (tx_wr_en),
        .wr_addr (tx_wr_addr),
        .wr_data (tx_wr_data),
        .rd_addr (tx_rd_addr),
        .rd_data (tx_rd_data)
    );

    pkt_ram #(.DEPTH(DEPTH)) i_rx_ram (
        .clk     (clk),
        .wr_en   (rx_wr_en),
        .wr_addr (rx_wr_addr),
        .wr_data (rx_wr_data),
        .rd_addr (rx_rd_addr),
        .rd_data (rx_rd_data)
    );

    tx_bytes_ser i_tx_bytes_ser (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg       (cfg),
        .unread    (unread),
        .data      (tx_rd_data),
        .addr      (tx_rd_addr),
        .tx_permit (tx_permit),
        .rx        (rx),
        .tx        (tx),
        .tx_en     (tx_en),
        .tx_st     (tx_st)
    );

    rx_bytes_des #(.IDLE_BITS(IDLE_BITS)) i_rx_bytes_des (
        .clk       (clk),
        .reset_n   (reset_n),
        .cfg       (cfg),
        .rx        (rx),
        .wr_en     (rx_wr_en),
        .wr_addr   (rx_wr_addr),
        .wr_data   (rx_wr_data),
        .tx_permit (tx_permit),
        .rx_st     (rx_st)
    );

endmodule

//--- cdbus_tb.sv
`timescale 1ns/1ns
// ############################################################
// cdbus node testbench with an apb host, a loopback bus with
// forced collisions and a crc-16 reference model
// ############################################################
module cdbus_tb
    import cdbus_pkg::*;
();

    localparam int DIV_LS      = 16;
    localparam int DIV_HS      = 8;
    localparam int IDLE_BITS   = 10;
    // longest frame has 8 payload bytes and a 4 bit delay head
    localparam int FRAME_MAX   = 10 * DIV_LS + 10 * (8 + 4) * DIV_HS + 4 * DIV_LS;
    localparam int NUM_FRAMES  = 10;
    localparam int CYCLE_LIMIT = 4 * NUM_FRAMES * FRAME_MAX + 2000;
    localparam int WAIT_LIMIT  = 3 * FRAME_MAX;
    localparam int WINDOW      = 9 * DIV_LS;  // inside the first character
    localparam int REARM_IDLE  = 10 * DIV_LS; // longer than any high run in a frame

    logic              clk = 1'b0;
    logic              reset_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              tx;
    logic              tx_en;
    logic              rx;
    logic              force_low = 1'b0;
    logic              collide;
    logic              arb_mode;

    int        errors = 0;     // checks in the main sequence
    int        bus_errors = 0; // checks in the bus monitor
    int        cycles = 0;
    int        win_cnt = 0;
    int        idle_run = 0;
    int        en_rises = 0;
    logic      armed = 1'b1;
    logic      tx_q = 1'b1;
    logic      tx_en_q = 1'b0;
    ram_data_t frame [$];

    // pulled up unless the node drives it or a collision pulls it low
    assign rx = force_low ? 1'b0 : (tx_en ? tx : 1'b1);

    always #5 clk = ~clk;

    cdbus_ctrl #(
        .DEPTH     (256),
        .IDLE_BITS (IDLE_BITS)
    ) i_cdbus_ctrl (
        .clk     (clk),
        .reset_n (reset_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .tx      (tx),
        .tx_en   (tx_en),
        .rx      (rx)
    );

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errors++;
            $display("mismatch %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1; // write lands on the next rising edge
        check_value("apb write pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        data    = prdata; // settled since the setup phase
        check_value("apb read pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // modbus crc over the first len bytes of the frame
    function automatic logic [15:0] crc16_modbus(input int len);
        logic [15:0] crc;
        crc = 16'hFFFF;
        for (int i = 0; i < len; i++) begin
            crc = crc ^ {8'h00, frame[i]};
            for (int k = 0; k < 8; k++)
                crc = crc[0] ? ((crc >> 1) ^ 16'hA001) : (crc >> 1);
        end
        return crc;
    endfunction

    task automatic build_frame(input int n);
        logic [31:0] r;
        logic [15:0] crc;
        frame.delete();
        r = $urandom;
        frame.push_back(r[7:0] | 8'h01); // source with bit 0 set so arbitration can lose
        frame.push_back(r[15:8]);
        frame.push_back(n[7:0]);
        for (int i = 0; i < n; i++) begin
            r = $urandom;
            frame.push_back(r[7:0]);
        end
        crc = crc16_modbus(n + 3);
        frame.push_back(crc[7:0]);
        frame.push_back(crc[15:8]);
    endtask

    // write count bytes into the tx buffer and start
    task automatic load_frame(input int count, input logic bad_crc);
        ram_data_t b;
        for (int i = 0; i < count; i++) begin
            b = frame[i];
            if (bad_crc && i >= count - 2)
                b = b ^ 8'h5A;
            apb_write(REG_TX_DATA, {24'd0, b});
        end
        apb_write(REG_TX_START, 32'h1);
    endtask

    task automatic wait_status(input string name, input logic [31:0] mask,
                               output logic [31:0] st);
        int waited;
        waited = 0;
        apb_read(REG_STATUS, st);
        while ((st & mask) != mask && waited < WAIT_LIMIT) begin
            apb_read(REG_STATUS, st);
            waited = waited + 3;
        end
        assert ((st & mask) == mask) else begin
            errors++;
            $display("%s: status bits 0x%0h were never set, status 0x%0h", name, mask, st);
        end
    endtask

    task automatic check_frame_end(input string name, input int n, input logic [31:0] st,
                                   input logic crc_err);
        check_value({name, " rx_crc_err"}, crc_err, st[3]);
        check_value({name, " frame_len"}, n + 4, st[15:8]);
        check_value({name, " unread"}, 0, st[4]);
        repeat (2) @(negedge clk);
        check_value({name, " tx_en after done"}, 0, tx_en);
        apb_write(REG_STATUS, 32'hF);
    endtask

    // bus monitor for the first-character window, forced collisions and drive rules
    always @(negedge clk) begin
        if (rx && idle_run < REARM_IDLE)
            idle_run = idle_run + 1;
        else if (!rx)
            idle_run = 0;
        if (idle_run >= REARM_IDLE)
            armed = 1'b1;
        if (win_cnt > 0) begin
            win_cnt = win_cnt - 1;
        end else if (armed && tx_q && !tx && tx_en) begin
            win_cnt = WINDOW; // start bit of a new frame
            armed   = 1'b0;
        end
        if (tx_en && !tx_en_q)
            en_rises = en_rises + 1;
        tx_q      = tx;
        tx_en_q   = tx_en;
        force_low = collide && win_cnt > 0 && tx && !tx_en;
        if (reset_n) begin
            assert (tx || tx_en) else begin
                bus_errors++;
                $display("tx is low while tx_en is off");
            end
            if (arb_mode && win_cnt > 0) begin
                assert (!(tx && tx_en)) else begin
                    bus_errors++;
                    $display("tx_en is on for a 1 bit in the first character");
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("check errors %0d, bus errors %0d, timeouts 1", errors, bus_errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        logic [31:0] st;
        logic [31:0] rd;
        logic [31:0] r;
        int          n;
        int          rises;
        r        = $urandom(32'h3c3f_e931);
        reset_n  = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        collide  = 1'b0;
        arb_mode = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;

        check_value("reset tx_en", 0, tx_en);
        check_value("reset tx", 1, tx);
        apb_read(REG_STATUS, st);
        check_value("reset status", 0, st);

        apb_write(REG_DIV, (DIV_HS << 16) | DIV_LS);
        apb_write(REG_CTRL, 32'h4); // one extra head bit and no arbitration

        // loopback with hardware crc
        r = $urandom;
        n = r[2:0] + 1;
        build_frame(n);
        rises = en_rises;
        load_frame(n + 3, 1'b0);
        wait_status("loopback", 32'h5, st);
        check_value("loopback tx_en rises", 1, en_rises - rises);
        check_frame_end("loopback", n, st, 1'b0);
        for (int i = 0; i < n + 5; i++) begin
            apb_read(REG_RX_DATA, rd);
            check_value($sformatf("loopback rx byte %0d", i), frame[i], rd[7:0]);
        end

        // host supplied crc that is wrong and then right
        apb_write(REG_CTRL, 32'h1);
        r = $urandom;
        n = r[2:0] + 1;
        build_frame(n);
        load_frame(n + 5, 1'b1);
        wait_status("user crc bad", 32'h5, st);
        check_frame_end("user crc bad", n, st, 1'b1);
        build_frame(n);
        load_frame(n + 5, 1'b0);
        wait_status("user crc good", 32'h5, st);
        check_frame_end("user crc good", n, st, 1'b0);

        // start while busy gives a single frame
        apb_write(REG_CTRL, 32'h0);
        r = $urandom;
        n = r[2:0] + 1;
        build_frame(n);
        load_frame(n + 3, 1'b0);
        apb_write(REG_TX_START, 32'h1);
        wait_status("busy start", 32'h5, st);
        check_frame_end("busy start", n, st, 1'b0);
        repeat (FRAME_MAX + 2 * IDLE_BITS * DIV_LS) @(negedge clk);
        apb_read(REG_STATUS, st);
        check_value("busy start second frame", 0, st[4:0]);

        // every first-byte 1 bit loses so four tries end in cd_err
        arb_mode = 1'b1;
        apb_write(REG_CTRL, 32'h2);
        collide = 1'b1;
        r = $urandom;
        n = r[2:0] + 1;
        build_frame(n);
        load_frame(n + 3, 1'b0);
        wait_status("collision", 32'h2, st);
        check_value("collision tx_done", 0, st[0]);
        check_value("collision unread", 0, st[4]);
        collide = 1'b0;
        apb_write(REG_STATUS, 32'hF);

        build_frame(n);
        load_frame(n + 3, 1'b0);
        wait_status("arbitrated frame", 32'h5, st);
        check_frame_end("arbitrated frame", n, st, 1'b0);

        $display("check errors %0d, bus errors %0d, timeouts 0", errors, bus_errors);
        if (errors == 0 && bus_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- cdbus_ctrl.f
cdbus_pkg.sv
serial_crc.sv
pkt_ram.sv
tx_bytes_ser.sv
rx_bytes_des.sv
cdbus_regs.sv
cdbus_ctrl.sv
cdbus_tb.sv
